//--- hazardCore.f
+incdir+rtl
rtl/hazardPkg.sv
rtl/pipeStage.sv
rtl/bypassSelect.sv
rtl/stallControl.sv
rtl/hazardConfig.sv
rtl/hazardCore.sv
tests/hazardCore_asserts.sv
tests/hazardCore_tb.sv

//--- Makefile
# Verilator build and run for the hazard control unit

VERILATOR ?= verilator
TOP       ?= hazardCore_tb
FILELIST  ?= hazardCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/hazardCore_tb.sv
`include "hazard_settings.svh"

module hazardCore_tb
	import hazardPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ResetCycles = 10;
	localparam int RandCycles = 1200; // Sum of all random phases
	localparam int CycleLimit = ResetCycles + RandCycles + 300; // Directed phases plus margin

	logic                    clk;
	logic                    rstN;
	logic                    idValid;
	regAddrT                 idRs;
	regAddrT                 idRt;
	regAddrT                 idRd;
	logic                    idRfWr;
	logic                    idLoad;
	logic                    idBranch;
	logic                    iCacheDataOk;
	logic                    dCacheEn;
	logic                    dCacheDataOk;
	logic                    memFlush;
	logic                    cfgWr;
	logic                    cfgAddr;
	logic [`STALL_CNT_W-1:0] cfgWrData;
	logic [`STALL_CNT_W-1:0] cfgRdData;
	logic                    pcWr;
	logic                    ifIdWr;
	logic                    idExWr;
	logic                    exMem1Wr;
	logic                    mem1Mem2Wr;
	logic                    bubbleSel;
	fwdSelT                  rsFwdSel;
	fwdSelT                  rtFwdSel;
	int                      cycleCount;
	int                      errCount;

	hazardCore u_hazardCore (.*);

	always #2 clk = ~clk; // 4 ns period

	task automatic setInstr(input logic valid, input regAddrT rs, input regAddrT rt,
			input regAddrT rd, input logic rfWr, input logic isLoad, input logic branch);
		idValid  = valid;
		idRs     = rs;
		idRt     = rt;
		idRd     = rd;
		idRfWr   = rfWr;
		idLoad   = isLoad;
		idBranch = branch;
	endtask

	task automatic setCache(input logic iOk, input logic dEn, input logic dOk);
		iCacheDataOk = iOk;
		dCacheEn     = dEn;
		dCacheDataOk = dOk;
	endtask

	task automatic writeConfig(input logic addr, input logic [`STALL_CNT_W-1:0] data);
		@(negedge clk);
		cfgWr     = 1'b1;
		cfgAddr   = addr;
		cfgWrData = data;
		@(negedge clk);
		cfgWr   = 1'b0;
		cfgAddr = `CFG_ADDR_COUNT;
	endtask

	// Registers 0 to 7 only, so matches come often
	task automatic randomPhase(input int cycles, input int waitPct, input int flushPct);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			setInstr($urandom_range(7) != 0, regAddrT'($urandom_range(7)),
				regAddrT'($urandom_range(7)), regAddrT'($urandom_range(7)),
				$urandom_range(3) != 0, $urandom_range(2) == 0, $urandom_range(3) == 0);
			setCache($urandom_range(99) >= waitPct, $urandom_range(1) == 1,
				$urandom_range(99) >= waitPct);
			memFlush = $urandom_range(99) < flushPct;
			cfgAddr  = 1'($urandom_range(1));
		end
	endtask

	// Producer of r, then a consumer of r held in ID
	task automatic hazardPair(input regAddrT r, input logic isLoad, input logic branch,
			input int hold);
		@(negedge clk);
		setInstr(1'b1, 5'd1, 5'd2, r, 1'b1, isLoad, 1'b0);
		repeat (hold) begin
			@(negedge clk);
			setInstr(1'b1, r, 5'd0, 5'd0, 1'b0, 1'b0, branch);
		end
	endtask

	initial begin
		cycleCount = 0;
		while (cycleCount < CycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout after %0d cycles with %0d assertion failures, stimulus never ended",
			cycleCount, u_hazardCore.u_asserts.failCount);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h4df7_9b39));
		clk  = 1'b0;
		rstN = 1'b0;
		setInstr(1'b0, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0);
		setCache(1'b1, 1'b0, 1'b1);
		memFlush  = 1'b0;
		cfgWr     = 1'b0;
		cfgAddr   = `CFG_ADDR_MASK;
		cfgWrData = '0;
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		@(negedge clk);
		cfgAddr = `CFG_ADDR_COUNT; // Mask read above, count read from here
		hazardPair(5'd3, 1'b1, 1'b0, 4); // Load-use through EX then MEM1
		hazardPair(5'd5, 1'b0, 1'b1, 3); // Branch compare on an EX result
		hazardPair(5'd4, 1'b1, 1'b0, 1);
		setCache(1'b0, 1'b0, 1'b1); // I-cache wait over a load-use
		repeat (3) @(negedge clk);
		setCache(1'b1, 1'b1, 1'b0);
		repeat (2) @(negedge clk);
		setCache(1'b1, 1'b0, 1'b1);
		repeat (3) @(negedge clk);
		hazardPair(5'd6, 1'b1, 1'b0, 1);
		memFlush     = 1'b1;
		iCacheDataOk = 1'b0; // Flush beats cache wait and load-use
		@(negedge clk);
		memFlush = 1'b0;
		setCache(1'b1, 1'b0, 1'b1);
		randomPhase(200, 5, 2);
		writeConfig(`CFG_ADDR_MASK, `STALL_CNT_W'(6)); // EX bypass off
		randomPhase(200, 5, 2);
		writeConfig(`CFG_ADDR_MASK, `STALL_CNT_W'(1)); // Only EX left
		randomPhase(200, 5, 2);
		writeConfig(`CFG_ADDR_MASK, `STALL_CNT_W'(0));
		randomPhase(100, 5, 2);
		writeConfig(`CFG_ADDR_MASK, `STALL_CNT_W'(7));
		writeConfig(`CFG_ADDR_COUNT, `STALL_CNT_W'(0));
		randomPhase(500, 5, 2);
		@(negedge clk);
		errCount = u_hazardCore.u_asserts.failCount;
		$display("Assertion failures: %0d, cycles run: %0d", errCount, cycleCount);
		if (errCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- tests/hazardCore_asserts.sv
`include "hazard_settings.svh"

module hazardCore_asserts
	import hazardPkg::*;
(
	input logic                    clk,
	input logic                    rstN,
	input logic                    idValid,
	input regAddrT                 idRs,
	input regAddrT                 idRt,
	input regAddrT                 idRd,
	input logic                    idRfWr,
	input logic                    idLoad,
	input logic                    idBranch,
	input logic                    iCacheDataOk,
	input logic                    dCacheEn,
	input logic                    dCacheDataOk,
	input logic                    memFlush,
	input logic                    cfgWr,
	input logic                    cfgAddr,
	input logic [`STALL_CNT_W-1:0] cfgWrData,
	input logic [`STALL_CNT_W-1:0] cfgRdData,
	input logic                    pcWr,
	input logic                    ifIdWr,
	input logic                    idExWr,
	input logic                    exMem1Wr,
	input logic                    mem1Mem2Wr,
	input logic                    bubbleSel,
	input fwdSelT                  rsFwdSel,
	input fwdSelT                  rtFwdSel
);

	timeunit 1ns;
	timeprecision 1ps;

	logic                    sValid [3]; // 0 EX, 1 MEM1, 2 MEM2
	regAddrT                 sRd [3];
	logic                    sWr [3];
	logic                    sLoad [3];
	logic [2:0]              mask;
	logic [`STALL_CNT_W-1:0] count;
	logic [`STALL_CNT_W-1:0] readExp;
	logic [2:0]              rsHit;
	logic [2:0]              rtHit;
	logic [1:0]              rsExp;
	logic [1:0]              rtExp;
	logic                    hazard;
	logic                    cacheWait;
	logic                    frontExp;
	logic                    backExp;
	logic                    bubbleExp;
	int                      failCount = 0;

	// Oldest source first so the newest usable one overwrites
	function automatic logic [1:0] firstUsable(input logic [2:0] hit, input logic [2:0] en);
		logic [1:0] sel;
		sel = 2'b00;
		for (int s = 2; s >= 0; s--)
			if (hit[s] && en[s])
				sel = 2'(s + 1);
		return sel;
	endfunction

	function automatic logic skipped(input logic [2:0] hit, input logic [2:0] en);
		logic b;
		b = 1'b0;
		for (int s = 2; s >= 0; s--)
			if (hit[s])
				b = !en[s];
		return b;
	endfunction

	always_comb begin
		for (int s = 0; s < 3; s++) begin
			rsHit[s] = sValid[s] && sWr[s] && (sRd[s] != '0) && (sRd[s] == idRs);
			rtHit[s] = sValid[s] && sWr[s] && (sRd[s] != '0) && (sRd[s] == idRt);
		end
		rsExp = firstUsable(rsHit, mask);
		rtExp = firstUsable(rtHit, mask);
		hazard = ((rsHit[0] || rtHit[0]) && sLoad[0]) || ((rsHit[1] || rtHit[1]) && sLoad[1]) ||
			(idBranch && (rsHit[0] || rtHit[0])) || skipped(rsHit, mask) || skipped(rtHit, mask);
		cacheWait = !iCacheDataOk || (dCacheEn && !dCacheDataOk);
		frontExp  = memFlush || (!cacheWait && !hazard);
		backExp   = memFlush || !cacheWait;
		bubbleExp = !memFlush && (cacheWait || hazard);
		readExp   = (cfgAddr == `CFG_ADDR_MASK) ? `STALL_CNT_W'(mask) : count;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int s = 0; s < 3; s++) begin
				sValid[s] <= 1'b0;
				sRd[s]    <= '0;
				sWr[s]    <= 1'b0;
				sLoad[s]  <= 1'b0;
			end
			mask  <= 3'b111;
			count <= '0;
		end else begin
			if (cfgWr && cfgAddr == `CFG_ADDR_MASK)
				mask <= cfgWrData[2:0];
			if (cfgWr && cfgAddr == `CFG_ADDR_COUNT)
				count <= '0;
			else if (hazard && !memFlush && !cacheWait && count != '1)
				count <= count + `STALL_CNT_W'(1);
			if (backExp) begin // Cache wait freezes every slot
				sValid[2] <= sValid[1];
				sRd[2]    <= sRd[1];
				sWr[2]    <= sWr[1];
				sLoad[2]  <= sLoad[1];
				sValid[1] <= sValid[0] && !memFlush;
				sRd[1]    <= sRd[0];
				sWr[1]    <= sWr[0];
				sLoad[1]  <= sLoad[0];
				sValid[0] <= idValid && !bubbleExp && !memFlush;
				sRd[0]    <= idRd;
				sWr[0]    <= idRfWr;
				sLoad[0]  <= idLoad;
			end
		end
	end

	rsSelA: assert property (@(posedge clk) disable iff (!rstN) rsFwdSel == rsExp)
		else begin
			$error("CHECK FAILED rsFwdSel exp %h got %h", $sampled(rsExp), $sampled(rsFwdSel));
			failCount++;
		end

	rtSelA: assert property (@(posedge clk) disable iff (!rstN) rtFwdSel == rtExp)
		else begin
			$error("CHECK FAILED rtFwdSel exp %h got %h", $sampled(rtExp), $sampled(rtFwdSel));
			failCount++;
		end

	zeroRegA: assert property (@(posedge clk) disable iff (!rstN)
			idRs == '0 |-> rsFwdSel == FWD_NONE)
		else begin
			$error("CHECK FAILED rsFwdSel exp %h got %h", 2'b00, $sampled(rsFwdSel));
			failCount++;
		end

	frontA: assert property (@(posedge clk) disable iff (!rstN)
			{pcWr, ifIdWr} == {2{frontExp}})
		else begin
			$error("CHECK FAILED pcWr/ifIdWr exp %h got %h", $sampled({2{frontExp}}),
				$sampled({pcWr, ifIdWr}));
			failCount++;
		end

	backA: assert property (@(posedge clk) disable iff (!rstN)
			{idExWr, exMem1Wr, mem1Mem2Wr} == {3{backExp}})
		else begin
			$error("CHECK FAILED idExWr/exMem1Wr/mem1Mem2Wr exp %h got %h",
				$sampled({3{backExp}}), $sampled({idExWr, exMem1Wr, mem1Mem2Wr}));
			failCount++;
		end

	bubbleA: assert property (@(posedge clk) disable iff (!rstN) bubbleSel == bubbleExp)
		else begin
			$error("CHECK FAILED bubbleSel exp %h got %h", $sampled(bubbleExp),
				$sampled(bubbleSel));
			failCount++;
		end

	cfgReadA: assert property (@(posedge clk) disable iff (!rstN) cfgRdData == readExp)
		else begin
			$error("CHECK FAILED cfgRdData exp %h got %h", $sampled(readExp),
				$sampled(cfgRdData));
			failCount++;
		end

endmodule

bind hazardCore hazardCore_asserts u_asserts (.*);

//--- rtl/hazardCore.sv
`include "hazard_settings.svh"

module hazardCore
	import hazardPkg::*;
(
	input  logic                    clk,
	input  logic                    rstN,
	input  logic                    idValid,
	input  regAddrT                 idRs,
	input  regAddrT                 idRt,
	input  regAddrT                 idRd,
	input  logic                    idRfWr,
	input  logic                    idLoad,
	input  logic                    idBranch,
	input  logic                    iCacheDataOk,
	input  logic                    dCacheEn,
	input  logic                    dCacheDataOk,
	input  logic                    memFlush,
	input  logic                    cfgWr,
	input  logic                    cfgAddr,
	input  logic [`STALL_CNT_W-1:0] cfgWrData,
	output logic [`STALL_CNT_W-1:0] cfgRdData,
	output logic                    pcWr,
	output logic                    ifIdWr,
	output logic                    idExWr,
	output logic                    exMem1Wr,
	output logic                    mem1Mem2Wr,
	output logic                    bubbleSel,
	output fwdSelT                  rsFwdSel,
	output fwdSelT                  rtFwdSel
);

	decodeInfoT idInfo;
	decodeInfoT exInfo;
	writeInfoT  exOut;
	writeInfoT  mem1Info;
	writeInfoT  mem2Info;
	logic [2:0] bypassMask;
	logic       rsBlocked;
	logic       rtBlocked;
	logic       dataStall;

	// Empty payload when ID holds nothing
	assign idInfo = idValid ? '{valid: 1'b1, rd: idRd, rfWr: idRfWr, isLoad: idLoad}
		: decodeInfoT'('0);

	assign exOut = '{valid: exInfo.valid, rd: exInfo.rd, rfWr: exInfo.rfWr,
		isLoad: exInfo.isLoad};

	pipeStage #(.payloadT(decodeInfoT)) exSlot (
		.clk(clk), .rstN(rstN), .load(idExWr), .kill(bubbleSel | memFlush),
		.din(idInfo), .dout(exInfo)
	);

	pipeStage #(.payloadT(writeInfoT)) mem1Slot (
		.clk(clk), .rstN(rstN), .load(exMem1Wr), .kill(memFlush),
		.din(exOut), .dout(mem1Info)
	);

	pipeStage #(.payloadT(writeInfoT)) mem2Slot (
		.clk(clk), .rstN(rstN), .load(mem1Mem2Wr), .kill(1'b0), // Past the flush point
		.din(mem1Info), .dout(mem2Info)
	);

	bypassSelect u_bypassSelect (
		.idRs(idRs), .idRt(idRt),
		.exInfo(exInfo), .mem1Info(mem1Info), .mem2Info(mem2Info),
		.bypassMask(bypassMask),
		.rsFwdSel(rsFwdSel), .rtFwdSel(rtFwdSel),
		.rsBlocked(rsBlocked), .rtBlocked(rtBlocked)
	);

	stallControl u_stallControl (
		.idRs(idRs), .idRt(idRt), .idBranch(idBranch),
		.exInfo(exInfo), .mem1Info(mem1Info),
		.rsBlocked(rsBlocked), .rtBlocked(rtBlocked),
		.iCacheDataOk(iCacheDataOk), .dCacheEn(dCacheEn),
		.dCacheDataOk(dCacheDataOk), .memFlush(memFlush),
		.pcWr(pcWr), .ifIdWr(ifIdWr), .idExWr(idExWr),
		.exMem1Wr(exMem1Wr), .mem1Mem2Wr(mem1Mem2Wr),
		.bubbleSel(bubbleSel), .dataStall(dataStall)
	);

	hazardConfig u_hazardConfig (
		.clk(clk), .rstN(rstN),
		.cfgWr(cfgWr), .cfgAddr(cfgAddr),
		.cfgWrData(cfgWrData), .cfgRdData(cfgRdData),
		.dataStall(dataStall), .bypassMask(bypassMask)
	);

endmodule

//--- rtl/hazardConfig.sv
`include "hazard_settings.svh"

module hazardConfig (
	input  logic                    clk,
	input  logic                    rstN,
	input  logic                    cfgWr,
	input  logic                    cfgAddr,
	input  logic [`STALL_CNT_W-1:0] cfgWrData,
	output logic [`STALL_CNT_W-1:0] cfgRdData,
	input  logic                    dataStall,
	output logic [2:0]              bypassMask
);

	logic [`STALL_CNT_W-1:0] stallCount;
	logic                    countFull;
	logic                    maskWr;
	logic                    countWr;

	assign maskWr    = cfgWr && (cfgAddr == `CFG_ADDR_MASK);
	assign countWr   = cfgWr && (cfgAddr == `CFG_ADDR_COUNT);
	assign countFull = &stallCount;

	// Bit 0 EX, bit 1 MEM1, bit 2 MEM2
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			bypassMask <= `BYPASS_MASK_RST;
		else if (maskWr)
			bypassMask <= cfgWrData[2:0];
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			stallCount <= '0;
		end else if (countWr) begin
			stallCount <= '0; // Any write clears
		end else if (dataStall && !countFull) begin
			stallCount <= stallCount + 1'b1; // Sticks at max
		end
	end

	always_comb begin
		if (cfgAddr == `CFG_ADDR_MASK)
			cfgRdData = {{(`STALL_CNT_W - 3){1'b0}}, bypassMask};
		else
			cfgRdData = stallCount;
	end

endmodule

//--- rtl/stallControl.sv
module stallControl
	import hazardPkg::*;
(
	input  regAddrT    idRs,
	input  regAddrT    idRt,
	input  logic       idBranch,
	input  decodeInfoT exInfo,
	input  writeInfoT  mem1Info,
	input  logic       rsBlocked,
	input  logic       rtBlocked,
	input  logic       iCacheDataOk,
	input  logic       dCacheEn,
	input  logic       dCacheDataOk,
	input  logic       memFlush,
	output logic       pcWr,
	output logic       ifIdWr,
	output logic       idExWr,
	output logic       exMem1Wr,
	output logic       mem1Mem2Wr,
	output logic       bubbleSel,
	output logic       dataStall
);

	logic exHit;
	logic mem1Hit;
	logic exLoadUse;
	logic mem1LoadUse;
	logic branchUse;
	logic dataHazard;
	logic cacheWait;

	assign exHit = regHit(exInfo.valid, exInfo.rfWr, exInfo.rd, idRs) ||
		regHit(exInfo.valid, exInfo.rfWr, exInfo.rd, idRt);
	assign mem1Hit = regHit(mem1Info.valid, mem1Info.rfWr, mem1Info.rd, idRs) ||
		regHit(mem1Info.valid, mem1Info.rfWr, mem1Info.rd, idRt);

	assign exLoadUse   = exHit && exInfo.isLoad; // Load data not back yet
	assign mem1LoadUse = mem1Hit && mem1Info.isLoad;
	assign branchUse   = idBranch && exHit; // Compare sits in ID

	assign dataHazard = exLoadUse || mem1LoadUse || branchUse || rsBlocked || rtBlocked;
	assign cacheWait  = !iCacheDataOk || (dCacheEn && !dCacheDataOk);

	// Only cycles where the data hazard really freezes the front
	assign dataStall = dataHazard && !memFlush && !cacheWait;

	always_comb begin
		if (memFlush) begin
			pcWr       = 1'b1;
			ifIdWr     = 1'b1;
			idExWr     = 1'b1;
			exMem1Wr   = 1'b1;
			mem1Mem2Wr = 1'b1;
			bubbleSel  = 1'b0;
		end else if (cacheWait) begin
			pcWr       = 1'b0; // Whole pipe holds
			ifIdWr     = 1'b0;
			idExWr     = 1'b0;
			exMem1Wr   = 1'b0;
			mem1Mem2Wr = 1'b0;
			bubbleSel  = 1'b1;
		end else if (dataHazard) begin
			pcWr       = 1'b0; // Freeze front, drain back
			ifIdWr     = 1'b0;
			idExWr     = 1'b1;
			exMem1Wr   = 1'b1;
			mem1Mem2Wr = 1'b1;
			bubbleSel  = 1'b1;
		end else begin
			pcWr       = 1'b1;
			ifIdWr     = 1'b1;
			idExWr     = 1'b1;
			exMem1Wr   = 1'b1;
			mem1Mem2Wr = 1'b1;
			bubbleSel  = 1'b0;
		end
	end

endmodule

//--- rtl/bypassSelect.sv
module bypassSelect
	import hazardPkg::*;
(
	input  regAddrT    idRs,
	input  regAddrT    idRt,
	input  decodeInfoT exInfo,
	input  writeInfoT  mem1Info,
	input  writeInfoT  mem2Info,
	input  logic [2:0] bypassMask,
	output fwdSelT     rsFwdSel,
	output fwdSelT     rtFwdSel,
	output logic       rsBlocked,
	output logic       rtBlocked
);

	logic [2:0] rsHits;
	logic [2:0] rtHits;

	// Newest enabled source wins
	function automatic fwdSelT pickSel(input logic [2:0] hits, input logic [2:0] mask);
		logic [2:0] usable;
		usable = hits & mask;
		if (usable[0])
			return FWD_EX;
		else if (usable[1])
			return FWD_MEM1;
		else if (usable[2])
			return FWD_MEM2;
		else
			return FWD_NONE;
	endfunction

	// Newest raw match has its source switched off
	function automatic logic firstBlocked(input logic [2:0] hits, input logic [2:0] mask);
		if (hits[0])
			return !mask[0];
		else if (hits[1])
			return !mask[1];
		else if (hits[2])
			return !mask[2];
		else
			return 1'b0;
	endfunction

	// Bit 0 EX, bit 1 MEM1, bit 2 MEM2
	assign rsHits = {regHit(mem2Info.valid, mem2Info.rfWr, mem2Info.rd, idRs),
		regHit(mem1Info.valid, mem1Info.rfWr, mem1Info.rd, idRs),
		regHit(exInfo.valid, exInfo.rfWr, exInfo.rd, idRs)};
	assign rtHits = {regHit(mem2Info.valid, mem2Info.rfWr, mem2Info.rd, idRt),
		regHit(mem1Info.valid, mem1Info.rfWr, mem1Info.rd, idRt),
		regHit(exInfo.valid, exInfo.rfWr, exInfo.rd, idRt)};

	assign rsFwdSel  = pickSel(rsHits, bypassMask);
	assign rtFwdSel  = pickSel(rtHits, bypassMask);
	assign rsBlocked = firstBlocked(rsHits, bypassMask);
	assign rtBlocked = firstBlocked(rtHits, bypassMask);

endmodule

//--- rtl/pipeStage.sv
module pipeStage #(
	parameter type payloadT = logic [7:0]
) (
	input  logic    clk,
	input  logic    rstN,
	input  logic    load,
	input  logic    kill,
	input  payloadT din,
	output payloadT dout
);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			dout <= payloadT'('0); // Empty slot
		end else if (load) begin
			if (kill)
				dout <= payloadT'('0); // Bubble or flush
			else
				dout <= din;
		end
	end

endmodule

//--- rtl/hazardPkg.sv
`include "hazard_settings.svh"

package hazardPkg;

	typedef logic [`REG_ADDR_W-1:0] regAddrT;

	typedef enum logic [1:0] {
		FWD_NONE = 2'b00,
		FWD_EX   = 2'b01,
		FWD_MEM1 = 2'b10,
		FWD_MEM2 = 2'b11
	} fwdSelT;

	// ID to EX slot
	typedef struct packed {
		logic    valid;
		regAddrT rd;
		logic    rfWr;
		logic    isLoad;
	} decodeInfoT;

	// EX to MEM1 and MEM1 to MEM2 slots
	typedef struct packed {
		logic    valid;
		regAddrT rd;
		logic    rfWr;
		logic    isLoad;
	} writeInfoT;

	// A slot writing a nonzero register that an ID operand reads
	function automatic logic regHit(input logic valid, input logic rfWr,
			input regAddrT rd, input regAddrT op);
		return valid && rfWr && (rd != '0) && (rd == op);
	endfunction

endpackage

//--- rtl/hazard_settings.svh
`ifndef HAZARD_SETTINGS_SVH
`define HAZARD_SETTINGS_SVH

// Register file address width
`define REG_ADDR_W 5

// Data-stall counter, also the config data width
`define STALL_CNT_W 16

// Config port addresses
`define CFG_ADDR_MASK 1'b0
`define CFG_ADDR_COUNT 1'b1

// Reset value of the bypass mask, all sources on
`define BYPASS_MASK_RST 3'b111

`endif
